// ==== source/td_macros.svh ====
// widths and constants for the time distribution receiver, included by every RTL file
`ifndef TD_MACROS_SVH
`define TD_MACROS_SVH

// serial framing
`define TD_WORD_W 16
`define TD_SDI_PIPELINE 2

// time-of-day and relative timestamp fields
`define TOD_S_W 48
`define TOD_NS_W 30
`define REL_NS_W 32
`define TS_FNS_W 16
`define TS_TAG_W 8

// word 0 bit that swaps current and alternate
`define TD_SEL_BIT 9

`endif

// ==== source/td_pkg.sv ====
// shared types of the time distribution receiver, imported by the control and bank blocks
package td_pkg;

    // framing states of the serial receiver
    typedef enum logic [1:0] {
        TD_IDLE,
        TD_DATA,
        TD_LINK
    } td_state_e;

    // message type from word 0 bits 3:0
    typedef enum logic [3:0] {
        // words 3..5 are current seconds
        TD_MSG_CUR_S   = 4'd0,
        // words 1..2 are current offset
        TD_MSG_CUR_OFS = 4'd1,
        // offset in words 1..2, seconds in words 3..5
        TD_MSG_ALT     = 4'd2
    } td_msg_e;

endpackage

// ==== source/td_rx_shift.sv ====
// serial input retiming and deserializer, holds each received word until the next capture
`timescale 1ns/1ps
`include "td_macros.svh"

module td_rx_shift (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sdi,
    input  logic                  capture,
    output logic                  sdi_bit,
    output logic [`TD_WORD_W-1:0] shift_bits,
    output logic [`TD_WORD_W-1:0] word
);

    logic [`TD_SDI_PIPELINE-1:0] sdi_pipe;

    // retiming chain, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            sdi_pipe <= '1;
        end else begin
            sdi_pipe[0] <= sdi;
            for (int i = 1; i < `TD_SDI_PIPELINE; i++) begin
                sdi_pipe[i] <= sdi_pipe[i-1];
            end
        end
    end

    assign sdi_bit = sdi_pipe[`TD_SDI_PIPELINE-1];

    // lsb first, new bit enters at the top
    always_ff @(posedge clk) begin
        shift_bits <= {sdi_bit, shift_bits[`TD_WORD_W-1:1]};
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            word <= shift_bits;
        end
    end

endmodule

// ==== source/td_rx_ctrl.sv ====
// framing control for the serial link, finds word boundaries and tags words with index and type
`timescale 1ns/1ps
`include "td_macros.svh"

module td_rx_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sdi_bit,
    input  logic [`TD_WORD_W-1:0] shift_bits,
    output logic                  capture,
    output logic                  word_valid,
    output logic [3:0]            word_index,
    output td_pkg::td_msg_e       word_msg
);

    import td_pkg::*;

    localparam int CNT_W = $clog2(`TD_WORD_W + 1);

    td_state_e        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [3:0]       index;
    td_msg_e          msg;

    // link bit is on sdi_bit, all data bits are in the shifter
    assign capture = (state == TD_LINK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= TD_IDLE;
            bit_cnt    <= '0;
            index      <= '0;
            msg        <= TD_MSG_CUR_S;
            word_valid <= 1'b0;
            word_index <= '0;
            word_msg   <= TD_MSG_CUR_S;
        end else begin
            word_valid <= capture;
            case (state)
                TD_IDLE: begin
                    // start bit
                    if (!sdi_bit) begin
                        state   <= TD_DATA;
                        bit_cnt <= CNT_W'(`TD_WORD_W);
                    end
                end
                TD_DATA: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == CNT_W'(1)) begin
                        state <= TD_LINK;
                    end
                end
                TD_LINK: begin
                    word_index <= index;
                    if (index == 4'd0) begin
                        // type comes with word 0 itself
                        word_msg <= td_msg_e'(shift_bits[3:0]);
                        msg      <= td_msg_e'(shift_bits[3:0]);
                    end else begin
                        word_msg <= msg;
                    end
                    if (!sdi_bit) begin
                        // link bit 0 doubles as the next start bit
                        state   <= TD_DATA;
                        bit_cnt <= CNT_W'(`TD_WORD_W);
                        index   <= index + 1'b1;
                    end else begin
                        state <= TD_IDLE;
                        index <= '0;
                    end
                end
                default: begin
                    state <= TD_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/td_tod_bank.sv ====
// current and alternate time-of-day registers, written in 16-bit slices from decoded link words
`timescale 1ns/1ps
`include "td_macros.svh"

module td_tod_bank (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  word_valid,
    input  logic [3:0]            word_index,
    input  td_pkg::td_msg_e       word_msg,
    input  logic [`TD_WORD_W-1:0] word,
    output logic [`TOD_S_W-1:0]   sec0,
    output logic [`TOD_S_W-1:0]   sec1,
    output logic [`REL_NS_W-1:0]  ofs0,
    output logic [`REL_NS_W-1:0]  ofs1
);

    import td_pkg::*;

    logic       sel;
    logic       tgt;
    logic       ofs_wr;
    logic       sec_wr;
    logic       ofs_slot;
    logic [1:0] sec_slot;

    always_comb begin
        // current goes to set sel, alternate to the other set
        tgt = (word_msg == TD_MSG_ALT) ? ~sel : sel;

        ofs_wr = (word_msg == TD_MSG_CUR_OFS || word_msg == TD_MSG_ALT) &&
                 (word_index == 4'd1 || word_index == 4'd2);
        sec_wr = (word_msg == TD_MSG_CUR_S || word_msg == TD_MSG_ALT) &&
                 (word_index >= 4'd3 && word_index <= 4'd5);

        // low slice first
        ofs_slot = (word_index == 4'd2);
        sec_slot = 2'(word_index - 4'd3);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel  <= 1'b0;
            sec0 <= '0;
            sec1 <= '0;
            ofs0 <= '0;
            ofs1 <= '0;
        end else if (word_valid) begin
            if (word_index == 4'd0) begin
                sel <= word[`TD_SEL_BIT];
            end
            if (ofs_wr) begin
                if (tgt) begin
                    ofs1[ofs_slot*`TD_WORD_W +: `TD_WORD_W] <= word;
                end else begin
                    ofs0[ofs_slot*`TD_WORD_W +: `TD_WORD_W] <= word;
                end
            end
            if (sec_wr) begin
                if (tgt) begin
                    sec1[sec_slot*`TD_WORD_W +: `TD_WORD_W] <= word;
                end else begin
                    sec0[sec_slot*`TD_WORD_W +: `TD_WORD_W] <= word;
                end
            end
        end
    end

endmodule

// ==== source/td_tod_rebuild.sv ====
// converts relative timestamps to time of day by adding both offsets and keeping the valid sum
`timescale 1ns/1ps
`include "td_macros.svh"

module td_tod_rebuild (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ts_rel_valid,
    input  logic [`REL_NS_W-1:0] ts_rel_ns,
    input  logic [`TS_FNS_W-1:0] ts_rel_fns,
    input  logic [`TS_TAG_W-1:0] ts_rel_tag,
    input  logic [`TOD_S_W-1:0]  sec0,
    input  logic [`TOD_S_W-1:0]  sec1,
    input  logic [`REL_NS_W-1:0] ofs0,
    input  logic [`REL_NS_W-1:0] ofs1,
    output logic                 ts_tod_valid,
    output logic [`TOD_S_W-1:0]  ts_tod_s,
    output logic [`TOD_NS_W-1:0] ts_tod_ns,
    output logic [`TS_FNS_W-1:0] ts_tod_fns,
    output logic [`TS_TAG_W-1:0] ts_tod_tag
);

    logic [`TOD_NS_W:0] ns0;
    logic [`TOD_NS_W:0] ns1;
    logic               use0;

    always_comb begin
        ns0 = (`TOD_NS_W+1)'(ts_rel_ns + ofs0);
        ns1 = (`TOD_NS_W+1)'(ts_rel_ns + ofs1);
        // top two bits clear is the safe lower range, top bit set means wrapped
        use0 = (ns0[`TOD_NS_W -: 2] == 2'b00) ||
               (!ns0[`TOD_NS_W] && ns1[`TOD_NS_W -: 2] != 2'b00);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ts_tod_valid <= 1'b0;
        end else begin
            ts_tod_valid <= ts_rel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (use0) begin
            ts_tod_s  <= sec0;
            ts_tod_ns <= ns0[`TOD_NS_W-1:0];
        end else begin
            ts_tod_s  <= sec1;
            ts_tod_ns <= ns1[`TOD_NS_W-1:0];
        end
        ts_tod_fns <= ts_rel_fns;
        ts_tod_tag <= ts_rel_tag;
    end

endmodule

// ==== source/td_rel2tod.sv ====
// top of the time distribution receiver, decodes the serial link and rebuilds ToD timestamps
`timescale 1ns/1ps
`include "td_macros.svh"

module td_rel2tod (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sdi,
    input  logic                 ts_rel_valid,
    input  logic [`REL_NS_W-1:0] ts_rel_ns,
    input  logic [`TS_FNS_W-1:0] ts_rel_fns,
    input  logic [`TS_TAG_W-1:0] ts_rel_tag,
    output logic                 ts_tod_valid,
    output logic [`TOD_S_W-1:0]  ts_tod_s,
    output logic [`TOD_NS_W-1:0] ts_tod_ns,
    output logic [`TS_FNS_W-1:0] ts_tod_fns,
    output logic [`TS_TAG_W-1:0] ts_tod_tag
);

    import td_pkg::*;

    logic                  sdi_bit;
    logic                  capture;
    logic [`TD_WORD_W-1:0] shift_bits;
    logic [`TD_WORD_W-1:0] word;
    logic                  word_valid;
    logic [3:0]            word_index;
    td_msg_e               word_msg;
    logic [`TOD_S_W-1:0]   sec0;
    logic [`TOD_S_W-1:0]   sec1;
    logic [`REL_NS_W-1:0]  ofs0;
    logic [`REL_NS_W-1:0]  ofs1;

    td_rx_shift i_td_rx_shift (
        .clk        (clk),
        .rst        (rst),
        .sdi        (sdi),
        .capture    (capture),
        .sdi_bit    (sdi_bit),
        .shift_bits (shift_bits),
        .word       (word)
    );

    td_rx_ctrl i_td_rx_ctrl (
        .clk        (clk),
        .rst        (rst),
        .sdi_bit    (sdi_bit),
        .shift_bits (shift_bits),
        .capture    (capture),
        .word_valid (word_valid),
        .word_index (word_index),
        .word_msg   (word_msg)
    );

    td_tod_bank i_td_tod_bank (
        .clk        (clk),
        .rst        (rst),
        .word_valid (word_valid),
        .word_index (word_index),
        .word_msg   (word_msg),
        .word       (word),
        .sec0       (sec0),
        .sec1       (sec1),
        .ofs0       (ofs0),
        .ofs1       (ofs1)
    );

    td_tod_rebuild i_td_tod_rebuild (
        .clk          (clk),
        .rst          (rst),
        .ts_rel_valid (ts_rel_valid),
        .ts_rel_ns    (ts_rel_ns),
        .ts_rel_fns   (ts_rel_fns),
        .ts_rel_tag   (ts_rel_tag),
        .sec0         (sec0),
        .sec1         (sec1),
        .ofs0         (ofs0),
        .ofs1         (ofs1),
        .ts_tod_valid (ts_tod_valid),
        .ts_tod_s     (ts_tod_s),
        .ts_tod_ns    (ts_tod_ns),
        .ts_tod_fns   (ts_tod_fns),
        .ts_tod_tag   (ts_tod_tag)
    );

endmodule

// ==== tests/td_serial_tasks.svh ====
// serial link drivers and random source for the receiver testbench, included in its top module
`ifndef TD_SERIAL_TASKS_SVH
`define TD_SERIAL_TASKS_SVH

logic [31:0] rng_state = 32'he1bd_264e;

// xorshift32 step
function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

task automatic send_bit(logic b);
    @(negedge clk);
    sdi = b;
endtask

// one start bit, then a link bit of 0 opens the next word
task automatic send_message(logic [95:0] words, int count);
    repeat (8) send_bit(1'b1);
    send_bit(1'b0);
    for (int w = 0; w < count; w++) begin
        for (int b = 0; b < `TD_WORD_W; b++) begin
            send_bit(words[16*w + b]);
        end
        send_bit(w == count - 1);
    end
    // line idles high until the bank has the new values
    repeat (10) send_bit(1'b1);
endtask

`endif

// ==== tests/tb_td_rel2tod.sv ====
// testbench for the time distribution receiver, sends link messages and checks rebuilt timestamps
`timescale 1ns/1ps
`include "td_macros.svh"

module tb_td_rel2tod;

    import td_pkg::*;

    logic                 clk;
    logic                 rst = 1'b1;
    logic                 sdi = 1'b1;
    logic                 ts_rel_valid = 1'b0;
    logic [`REL_NS_W-1:0] ts_rel_ns = '0;
    logic [`TS_FNS_W-1:0] ts_rel_fns = '0;
    logic [`TS_TAG_W-1:0] ts_rel_tag = '0;
    logic                 ts_tod_valid;
    logic [`TOD_S_W-1:0]  ts_tod_s;
    logic [`TOD_NS_W-1:0] ts_tod_ns;
    logic [`TS_FNS_W-1:0] ts_tod_fns;
    logic [`TS_TAG_W-1:0] ts_tod_tag;

    // mirror of the bank
    logic                 m_sel = 1'b0;
    logic [`TOD_S_W-1:0]  m_sec[2] = '{default: '0};
    logic [`REL_NS_W-1:0] m_ofs[2] = '{default: '0};

    // expected {seconds, ns, fns, tag} in output order
    logic [101:0]         exp_q[$];
    logic [101:0]         exp_now;
    logic                 rel_valid_prev = 1'b0;
    logic [31:0]          probes[6] = '{32'h0000_0000, 32'h0fff_ffff, 32'h1000_0000,
                                        32'h3000_0000, 32'h5000_0000, 32'hf000_0000};

    `include "td_serial_tasks.svh"

    td_rel2tod i_td_rel2tod (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_field(string name, logic [63:0] got, logic [63:0] want);
        assert (got == want) else begin
            $display("MISMATCH %s got %h expected %h", name, got, want);
            $display("FAIL: see errors above");
            $fatal(1, "output check failed");
        end
    endtask

    // new inputs are already applied here, registered outputs still hold the previous ones
    always @(negedge clk) begin
        #1;
        if (!rst) begin
            check_field("ts_tod_valid", 64'(ts_tod_valid), 64'(rel_valid_prev));
            if (ts_tod_valid) begin
                exp_now = exp_q.pop_front();
                check_field("ts_tod_s", 64'(ts_tod_s), 64'(exp_now[101:54]));
                check_field("ts_tod_ns", 64'(ts_tod_ns), 64'(exp_now[53:24]));
                check_field("ts_tod_fns", 64'(ts_tod_fns), 64'(exp_now[23:8]));
                check_field("ts_tod_tag", 64'(ts_tod_tag), 64'(exp_now[7:0]));
            end
        end
        rel_valid_prev = ts_rel_valid;
    end

    // word 0, offset in words 1..2, random seconds in words 3..5
    task automatic post_message(td_msg_e msg, logic sel, logic [31:0] ofs, int count);
        logic [95:0] words;
        logic        tgt;
        words = {16'(next_rand()), next_rand(), ofs, 16'(msg) | (16'(sel) << `TD_SEL_BIT)};
        m_sel = sel;
        // alternate writes land in the set that is not selected
        tgt = (msg == TD_MSG_ALT) ? !m_sel : m_sel;
        for (int i = 1; i < count; i++) begin
            if (i <= 2 && msg != TD_MSG_CUR_S)
                m_ofs[tgt][16*(i-1) +: 16] = words[16*i +: 16];
            else if (i >= 3 && i <= 5 && msg != TD_MSG_CUR_OFS)
                m_sec[tgt][16*(i-3) +: 16] = words[16*i +: 16];
        end
        send_message(words, count);
    endtask

    task automatic drive_ts(logic valid, logic [31:0] rel);
        logic [31:0] r;
        logic [31:0] s0;
        logic [31:0] s1;
        logic        pick;
        r = next_rand();
        s0 = (rel + m_ofs[0]) & 32'h7fff_ffff;
        s1 = (rel + m_ofs[1]) & 32'h7fff_ffff;
        // set 0 below 2^29, or below 2^30 when set 1 is not below 2^29
        pick = !(s0 < 32'h2000_0000 || (s0 < 32'h4000_0000 && s1 >= 32'h2000_0000));
        @(negedge clk);
        ts_rel_valid = valid;
        ts_rel_ns = rel;
        ts_rel_fns = r[15:0];
        ts_rel_tag = r[23:16];
        if (valid) begin
            exp_q.push_back({m_sec[pick], pick ? s1[29:0] : s0[29:0], r[15:0], r[23:16]});
        end
    endtask

    task automatic run_stamps(int count, logic back_to_back);
        for (int k = 0; k < count; k++) begin
            drive_ts(1'b1, next_rand());
            if (!back_to_back)
                drive_ts(1'b0, 32'd0);
        end
        drive_ts(1'b0, 32'd0);
        for (int n = 0; exp_q.size() != 0; n++) begin
            if (n == 20) begin
                $display("timed out waiting for rebuilt timestamps");
                $display("FAIL: see errors above");
                $fatal(1, "timeout");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        repeat (16) @(negedge clk);
        rst = 1'b0;
        // bank still zero
        run_stamps(8, 1'b0);
        run_stamps(8, 1'b1);
        post_message(TD_MSG_CUR_OFS, 1'b0, next_rand(), 3);
        post_message(TD_MSG_CUR_S, 1'b0, 32'd0, 6);
        run_stamps(16, 1'b1);
        // alternate set, swap, write through the new roles, swap back
        post_message(TD_MSG_ALT, 1'b0, next_rand(), 6);
        run_stamps(8, 1'b1);
        post_message(TD_MSG_CUR_S, 1'b1, 32'd0, 1);
        run_stamps(12, 1'b1);
        post_message(TD_MSG_CUR_OFS, 1'b1, next_rand(), 3);
        run_stamps(8, 1'b0);
        post_message(TD_MSG_CUR_S, 1'b0, 32'd0, 1);
        run_stamps(12, 1'b1);
        // sums near the 2^31 wrap and past 1e9
        post_message(TD_MSG_CUR_OFS, 1'b0, 32'h7000_0000, 3);
        post_message(TD_MSG_ALT, 1'b0, 32'h3c00_0000, 6);
        for (int k = 0; k < 6; k++)
            drive_ts(1'b1, probes[k]);
        run_stamps(8, 1'b1);
        // short message ends after word 2, then a full seconds message
        post_message(TD_MSG_CUR_OFS, 1'b0, next_rand(), 3);
        post_message(TD_MSG_CUR_S, 1'b0, 32'd0, 6);
        run_stamps(12, 1'b1);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+source
+incdir+tests
source/td_pkg.sv
source/td_rx_shift.sv
source/td_rx_ctrl.sv
source/td_tod_bank.sv
source/td_tod_rebuild.sv
source/td_rel2tod.sv
tests/tb_td_rel2tod.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f project.f --top-module tb_td_rel2tod \
    && ./obj_dir/Vtb_td_rel2tod \
    || exit 1
